/* build.f */
+incdir+common
common/membus_pkg.sv
design/lsu_ctrl.sv
design/master_bus_mux.sv
design/slave_bus_mux.sv
data_mem/data_mem.sv
design/mem_subsystem_top.sv
testbench/mem_subsystem_assert.sv
testbench/tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_subsystem -f build.f

output=$(./obj_dir/Vtb_mem_subsystem)
echo "$output"

if echo "$output" | grep -q "^STATUS: PASS$"; then
   exit 0
else
   exit 1
fi

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

`include "membus_defs.svh"

module tb_mem_subsystem
   import membus_pkg::*;
();

   localparam int Iters = 150;
   localparam int Words = 2**`MEM_ADDR_BITS;
   localparam int NumTests = 7;
   localparam int CyclesPerTest = 3 * Iters;
   localparam int WatchdogNs = (Words + 4 + NumTests * CyclesPerTest) * 8 + 2000;

   logic        clk;
   logic        arst_n;
   logic        probe_sel;
   word_addr_t  probe_addr;
   logic        probe_read;
   logic        probe_write;
   byte_mask_t  probe_mask;
   word_t       probe_wdata;
   word_t       probe_rdata;
   mem_access_t cpu_access;
   word_t       cpu_addr;
   word_t       cpu_wdata;
   word_t       cpu_load_data;
   logic        cpu_misaligned;
   word_t       pc;
   word_t       instruction;
   logic        invalid_address;
   logic [7:0]  uart_data;
   logic        uart_write;

   word_t model [Words];
   word_t lfsr_state = 32'h14219dd8;
   string cur_test;
   int    errors = 0;
   int    checks = 0;
   int    test_errors;
   int    test_checks;
   int    tests_run = 0;

   mem_subsystem_top UUT (
      .clk (clk), .arst_n_i (arst_n), .probe_sel_i (probe_sel),
      .probe_addr_i (probe_addr), .probe_read_i (probe_read),
      .probe_write_i (probe_write), .probe_mask_i (probe_mask),
      .probe_wdata_i (probe_wdata), .probe_rdata_o (probe_rdata),
      .cpu_access_i (cpu_access), .cpu_addr_i (cpu_addr), .cpu_wdata_i (cpu_wdata),
      .cpu_load_data_o (cpu_load_data), .cpu_misaligned_o (cpu_misaligned),
      .pc_i (pc), .instruction_o (instruction), .invalid_address_o (invalid_address),
      .uart_data_o (uart_data), .uart_write_o (uart_write)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      #(WatchdogNs);
      $display("watchdog expired before the tests finished");
      $display("STATUS: FAIL");
      $finish;
   end

   // galois lfsr stepped once for each bit taken.
   function automatic word_t rand_bits(input int n);
      word_t r;
      logic  lsb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lsb        = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb)
            lfsr_state = lfsr_state ^ 32'hA3000000;
         r = {r[30:0], lsb};
      end
      return r;
   endfunction

   function automatic logic [7:0] lane_byte(input word_t w, input logic [1:0] lane);
      word_t s;
      s = w >> (lane * 8);
      return s[7:0];
   endfunction

   function automatic word_t put_byte(input word_t w, input logic [1:0] lane,
                                      input logic [7:0] v);
      return (w & ~(32'hFF << (lane * 8))) | (32'(v) << (lane * 8));
   endfunction

   function automatic word_t merge_bytes(input word_t w, input byte_mask_t m, input word_t d);
      for (int k = 0; k < 4; k++) begin
         if (m[k])
            w = put_byte(w, 2'(k), lane_byte(d, 2'(k)));
      end
      return w;
   endfunction

   function automatic word_t store_model(input word_t w, input mem_access_t typ,
                                         input logic [1:0] off, input word_t d);
      case (typ)
         access_sb: return put_byte(w, off, d[7:0]);
         access_sh: return put_byte(put_byte(w, {off[1], 1'b0}, d[7:0]), {off[1], 1'b1}, d[15:8]);
         default:   return d;
      endcase
   endfunction

   function automatic word_t expected_load(input word_t w, input mem_access_t typ,
                                           input logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = lane_byte(w, off);
      h = off[1] ? w[31:16] : w[15:0];
      case (typ)
         access_lb:  return {{24{b[7]}}, b};
         access_lbu: return {24'h0, b};
         access_lh:  return {{16{h[15]}}, h};
         access_lhu: return {16'h0, h};
         default:    return w;
      endcase
   endfunction

   function automatic mem_access_t pick_store();
      word_t r;
      r = rand_bits(2);
      return (r[1:0] == 2'd0) ? access_sb : (r[1:0] == 2'd1) ? access_sh : access_sw;
   endfunction

   function automatic mem_access_t pick_load();
      word_t r;
      r = rand_bits(3);
      case (r[2:0])
         3'd0:    return access_lb;
         3'd1:    return access_lh;
         3'd2:    return access_lbu;
         3'd3:    return access_lhu;
         default: return access_lw;
      endcase
   endfunction

   // a random offset that is aligned for the access size.
   function automatic logic [1:0] pick_offset(input mem_access_t typ);
      word_t r;
      r = rand_bits(2);
      case (typ)
         access_sb, access_lb, access_lbu: return r[1:0];
         access_sh, access_lh, access_lhu: return {r[0], 1'b0};
         default:                          return 2'b00;
      endcase
   endfunction

   function automatic word_addr_t mem_word(input mem_index_t idx);
      return `MEM_BASE + word_addr_t'(idx);
   endfunction

   function automatic logic in_map(input word_addr_t a);
      return (a >= `MEM_BASE && a < `MEM_BASE + word_addr_t'(Words)) ||
             (a >= `UART_BASE && a < `UART_BASE + word_addr_t'(`UART_WORDS));
   endfunction

   task automatic check(input string what, input word_t expected, input word_t actual);
      checks++;
      test_checks++;
      if (expected !== actual) begin
         errors++;
         test_errors++;
         $display("** Error: %s %s expected %h actual %h", cur_test, what, expected, actual);
      end
   endtask

   // every cycle starts from an idle bus owned by the probe.
   task automatic next_cycle();
      @(posedge clk);
      #1;
      probe_sel   = 1'b1;
      probe_read  = 1'b0;
      probe_write = 1'b0;
      probe_mask  = '0;
      probe_wdata = '0;
      probe_addr  = `MEM_BASE;
      cpu_access  = access_none;
      cpu_addr    = '0;
      cpu_wdata   = '0;
   endtask

   task automatic probe_access(input word_addr_t addr, input logic rd, input logic wr,
                               input byte_mask_t mask, input word_t data);
      next_cycle();
      probe_addr  = addr;
      probe_read  = rd;
      probe_write = wr;
      probe_mask  = mask;
      probe_wdata = data;
      #5;
   endtask

   // when the processor does not own the bus the probe reads the same word.
   task automatic cpu_cycle(input mem_access_t typ, input word_t addr, input word_t data,
                            input logic own);
      next_cycle();
      probe_sel  = ~own;
      probe_read = ~own;
      probe_addr = addr[31:2];
      cpu_access = typ;
      cpu_addr   = addr;
      cpu_wdata  = data;
      #5;
   endtask

   task automatic begin_test(input string name);
      cur_test    = name;
      test_errors = 0;
      test_checks = 0;
   endtask

   task automatic end_test();
      tests_run++;
      $display("test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
   endtask

   initial begin
      word_t       r;
      word_t       d;
      mem_index_t  idx;
      mem_access_t typ;
      logic [1:0]  off;
      word_addr_t  a;
      word_addr_t  edges [4];
      arst_n = 1'b0;
      probe_sel = 1'b1;
      probe_addr = `UART_BASE;
      probe_read = 1'b0;
      probe_write = 1'b1;
      probe_mask = 4'hF;
      probe_wdata = '1;
      cpu_access = access_none;
      cpu_addr = '0;
      cpu_wdata = '0;
      pc = '0;

      // a console write held through reset must not reach the strobe.
      begin_test("reset_console");
      #2;
      check("console strobe in reset", 32'(1'b0), 32'(uart_write));
      repeat (3) @(posedge clk);
      #1;
      probe_write = 1'b0;
      probe_addr = `MEM_BASE;
      arst_n = 1'b1;
      end_test();

      // memory content is undefined after reset, so fill it first.
      for (int i = 0; i < Words; i++) begin
         d   = rand_bits(32);
         idx = mem_index_t'(i);
         probe_access(mem_word(idx), 1'b0, 1'b1, 4'hF, d);
         model[idx] = d;
      end

      begin_test("probe_masked_rw");
      for (int i = 0; i < Iters; i++) begin
         r = rand_bits(14);
         d = rand_bits(32);
         idx = r[9:0];
         probe_access(mem_word(idx), 1'b0, 1'b1, r[13:10], d);
         model[idx] = merge_bytes(model[idx], r[13:10], d);
         probe_access(mem_word(idx), 1'b1, 1'b0, 4'h0, '0);
         check("read data", model[idx], probe_rdata);
      end
      end_test();

      begin_test("cpu_load_store");
      for (int i = 0; i < Iters; i++) begin
         r = rand_bits(10);
         idx = r[9:0];
         d = rand_bits(32);
         typ = pick_store();
         off = pick_offset(typ);
         cpu_cycle(typ, {mem_word(idx), off}, d, 1'b1);
         model[idx] = store_model(model[idx], typ, off, d);
         typ = pick_load();
         off = pick_offset(typ);
         cpu_cycle(typ, {mem_word(idx), off}, '0, 1'b1);
         check("load data", expected_load(model[idx], typ, off), cpu_load_data);
         check("misaligned flag", 32'(1'b0), 32'(cpu_misaligned));
      end
      end_test();

      begin_test("cpu_misaligned");
      for (int i = 0; i < Iters; i++) begin
         r = rand_bits(12);
         idx = r[9:0];
         d = rand_bits(32);
         typ = r[10] ? access_sh : access_sw;
         off = r[10] ? {r[11], 1'b1} : (r[11] ? 2'b10 : 2'b01);
         cpu_cycle(typ, {mem_word(idx), off}, d, 1'b1);
         check("misaligned flag", 32'(1'b1), 32'(cpu_misaligned));
         probe_access(mem_word(idx), 1'b1, 1'b0, 4'h0, '0);
         check("memory after misaligned store", model[idx], probe_rdata);
      end
      end_test();

      begin_test("console_and_invalid");
      edges = '{`MEM_BASE - 30'd1, `MEM_BASE + word_addr_t'(Words),
                `UART_BASE - 30'd1, `UART_BASE + word_addr_t'(`UART_WORDS)};
      foreach (edges[k]) begin
         probe_access(edges[k], 1'b1, 1'b1, 4'hF, '1);
         check("invalid flag at map edge", 32'(1'b1), 32'(invalid_address));
      end
      for (int i = 0; i < Iters; i++) begin
         r = rand_bits(2);
         d = rand_bits(32);
         probe_access(`UART_BASE + word_addr_t'(r[1:0]), 1'b1, 1'b1, 4'hF, d);
         check("console strobe", 32'(1'b1), 32'(uart_write));
         check("console data", 32'(d[7:0]), 32'(uart_data));
         check("console read", '0, probe_rdata);
         check("invalid flag", 32'(1'b0), 32'(invalid_address));
         // the memory word that the console address would alias onto.
         idx = mem_index_t'(`UART_BASE + word_addr_t'(r[1:0]) - `MEM_BASE);
         probe_access(mem_word(idx), 1'b1, 1'b0, 4'h0, '0);
         check("memory after console write", model[idx], probe_rdata);
         r = rand_bits(30);
         a = r[29:0];
         if (in_map(a))
            a[29] = ~a[29];
         probe_access(a, 1'b1, 1'b1, 4'hF, d);
         check("invalid flag", 32'(1'b1), 32'(invalid_address));
         check("console strobe", 32'(1'b0), 32'(uart_write));
      end
      end_test();

      begin_test("probe_ownership");
      for (int i = 0; i < Iters; i++) begin
         r = rand_bits(10);
         idx = r[9:0];
         d = rand_bits(32);
         cpu_cycle(access_sw, {mem_word(idx), 2'b00}, d, 1'b0);
         cpu_cycle(access_lw, {mem_word(idx), 2'b00}, '0, 1'b0);
         check("cpu load while probe owns bus", '0, cpu_load_data);
         check("memory after blocked store", model[idx], probe_rdata);
      end
      end_test();

      begin_test("instruction_fetch");
      for (int i = 0; i < Iters; i++) begin
         r = rand_bits(15);
         d = rand_bits(32);
         idx = r[9:0];
         probe_access(mem_word(idx), 1'b0, 1'b1, r[13:10], d);
         model[idx] = merge_bytes(model[idx], r[13:10], d);
         next_cycle();
         pc = rand_bits(32);
         if (r[14])
            pc[`MEM_ADDR_BITS+1:2] = idx; // half the fetches hit the word just written.
         #5;
         check("instruction", model[pc[`MEM_ADDR_BITS+1:2]], instruction);
      end
      end_test();

      $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* testbench/mem_subsystem_assert.sv */
`timescale 1ns/1ps

module mem_subsystem_assert (
   input logic clk_i,
   input logic arst_n_i,
   input logic invalid_address_i,
   input logic mem_write_i,
   input logic uart_write_i,
   input logic misaligned_i,
   input logic probe_sel_i
);

   assert property (@(posedge clk_i) invalid_address_i |-> !mem_write_i && !uart_write_i)
      else $error("write strobe raised for an address outside the map");

   // a misaligned processor access must not reach the data memory.
   assert property (@(posedge clk_i) misaligned_i && !probe_sel_i |-> !mem_write_i)
      else $error("misaligned processor store reached the data memory");

   // the console must stay quiet while reset is held.
   assert property (@(posedge clk_i) !arst_n_i |-> !uart_write_i)
      else $error("console strobe raised during reset");

endmodule

bind mem_subsystem_top mem_subsystem_assert u_assert (
   .clk_i             (clk),
   .arst_n_i          (arst_n_i),
   .invalid_address_i (invalid_address_o),
   .mem_write_i       (mem_write),
   .uart_write_i      (uart_write_o),
   .misaligned_i      (cpu_misaligned_o),
   .probe_sel_i       (probe_sel_i)
);

/* design/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top
   import membus_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        probe_sel_i,
   input  word_addr_t  probe_addr_i,
   input  logic        probe_read_i,
   input  logic        probe_write_i,
   input  byte_mask_t  probe_mask_i,
   input  word_t       probe_wdata_i,
   output word_t       probe_rdata_o,
   input  mem_access_t cpu_access_i,
   input  word_t       cpu_addr_i,
   input  word_t       cpu_wdata_i,
   output word_t       cpu_load_data_o,
   output logic        cpu_misaligned_o,
   input  word_t       pc_i,
   output word_t       instruction_o,
   output logic        invalid_address_o,
   output logic [7:0]  uart_data_o,
   output logic        uart_write_o
);

   bus_cmd_t    probe_cmd;
   bus_cmd_t    cpu_cmd;
   bus_result_t cpu_result;
   word_addr_t  cpu_word_addr;
   logic        cpu_write;

   word_addr_t  bus_addr;
   logic        bus_write_req;
   logic        bus_write;
   bus_cmd_t    bus_cmd;
   bus_result_t bus_result;

   mem_index_t  mem_addr;
   logic        mem_write;
   bus_cmd_t    mem_cmd;
   bus_result_t mem_result;
   bus_cmd_t    uart_cmd;

   assign probe_cmd   = '{mem_read: probe_read_i, mask_byte: probe_mask_i,
                          write_data: probe_wdata_i};
   assign uart_data_o = uart_cmd.write_data[7:0];
   assign bus_write   = bus_write_req & arst_n_i; // reset holds every write strobe low.

   lsu_ctrl u_lsu_ctrl (
      .access_i     (cpu_access_i),
      .byte_addr_i  (cpu_addr_i),
      .store_data_i (cpu_wdata_i),
      .bus_result_i (cpu_result),
      .bus_cmd_o    (cpu_cmd),
      .write_o      (cpu_write),
      .word_addr_o  (cpu_word_addr),
      .load_data_o  (cpu_load_data_o),
      .misaligned_o (cpu_misaligned_o)
   );

   master_bus_mux u_master_bus_mux (
      .probe_sel_i  (probe_sel_i),
      .a_addr_i     (probe_addr_i),
      .a_write_i    (probe_write_i),
      .a_cmd_i      (probe_cmd),
      .a_result_o   (probe_rdata_o),
      .b_addr_i     (cpu_word_addr),
      .b_write_i    (cpu_write),
      .b_cmd_i      (cpu_cmd),
      .b_result_o   (cpu_result),
      .bus_addr_o   (bus_addr),
      .bus_write_o  (bus_write_req),
      .bus_cmd_o    (bus_cmd),
      .bus_result_i (bus_result)
   );

   slave_bus_mux u_slave_bus_mux (
      .addr_i            (bus_addr),
      .write_i           (bus_write),
      .cmd_i             (bus_cmd),
      .result_o          (bus_result),
      .invalid_address_o (invalid_address_o),
      .mem_addr_o        (mem_addr),
      .mem_write_o       (mem_write),
      .mem_cmd_o         (mem_cmd),
      .mem_result_i      (mem_result),
      .uart_write_o      (uart_write_o),
      .uart_cmd_o        (uart_cmd)
   );

   data_mem u_data_mem (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .write_i       (mem_write),
      .addr_i        (mem_addr),
      .cmd_i         (mem_cmd),
      .result_o      (mem_result),
      .pc_i          (pc_i),
      .instruction_o (instruction_o)
   );

endmodule

/* data_mem/data_mem.sv */
`timescale 1ns/1ps

`include "membus_defs.svh"

module data_mem
   import membus_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        write_i,
   input  mem_index_t  addr_i,
   input  bus_cmd_t    cmd_i,
   output bus_result_t result_o,
   input  word_t       pc_i,
   output word_t       instruction_o
);

   localparam int Words = 2**`MEM_ADDR_BITS;

   word_t      mem [Words];
   mem_index_t fetch_index;

   // each lane is written only when its mask bit is set.
   always_ff @(posedge clk) begin
      if (write_i && arst_n_i) begin
         for (int i = 0; i < 4; i++) begin
            if (cmd_i.mask_byte[i])
               mem[addr_i][8*i +: 8] <= cmd_i.write_data[8*i +: 8];
         end
      end
   end

   assign result_o = cmd_i.mem_read ? mem[addr_i] : '0;

   // fetch wraps around the memory size.
   assign fetch_index   = pc_i[`MEM_ADDR_BITS+1:2];
   assign instruction_o = mem[fetch_index];

endmodule

/* design/slave_bus_mux.sv */
`timescale 1ns/1ps

`include "membus_defs.svh"

module slave_bus_mux
   import membus_pkg::*;
(
   input  word_addr_t  addr_i,
   input  logic        write_i,
   input  bus_cmd_t    cmd_i,
   output bus_result_t result_o,
   output logic        invalid_address_o,
   // data memory.
   output mem_index_t  mem_addr_o,
   output logic        mem_write_o,
   output bus_cmd_t    mem_cmd_o,
   input  bus_result_t mem_result_i,
   // console.
   output logic        uart_write_o,
   output bus_cmd_t    uart_cmd_o
);

   localparam word_addr_t MemBase  = `MEM_BASE;
   localparam word_addr_t MemWords = word_addr_t'(2**`MEM_ADDR_BITS);
   localparam word_addr_t UartBase = `UART_BASE;
   localparam word_addr_t UartWords = word_addr_t'(`UART_WORDS);

   word_addr_t mem_offset;
   word_addr_t uart_offset;
   logic       mem_hit;
   logic       uart_hit;

   assign mem_offset  = addr_i - MemBase;
   assign uart_offset = addr_i - UartBase;

   // the lower bound check stops a wrapped offset from looking in range.
   assign mem_hit  = (addr_i >= MemBase) && (mem_offset < MemWords);
   assign uart_hit = (addr_i >= UartBase) && (uart_offset < UartWords);

   assign invalid_address_o = ~mem_hit & ~uart_hit;

   assign mem_addr_o  = mem_offset[`MEM_ADDR_BITS-1:0];
   assign mem_write_o = write_i & mem_hit;

   always_comb begin
      mem_cmd_o          = cmd_i;
      mem_cmd_o.mem_read = cmd_i.mem_read & mem_hit;
   end

   always_comb begin
      uart_cmd_o          = cmd_i;
      uart_cmd_o.mem_read = cmd_i.mem_read & uart_hit;
   end

   assign uart_write_o = write_i & uart_hit;

   assign result_o = mem_hit ? mem_result_i : '0; // the console has nothing to read.

endmodule

/* design/master_bus_mux.sv */
`timescale 1ns/1ps

module master_bus_mux
   import membus_pkg::*;
(
   input  logic        probe_sel_i,
   // probe side.
   input  word_addr_t  a_addr_i,
   input  logic        a_write_i,
   input  bus_cmd_t    a_cmd_i,
   output bus_result_t a_result_o,
   // processor side.
   input  word_addr_t  b_addr_i,
   input  logic        b_write_i,
   input  bus_cmd_t    b_cmd_i,
   output bus_result_t b_result_o,
   output word_addr_t  bus_addr_o,
   output logic        bus_write_o,
   output bus_cmd_t    bus_cmd_o,
   input  bus_result_t bus_result_i
);

   assign bus_addr_o  = probe_sel_i ? a_addr_i : b_addr_i;
   assign bus_write_o = probe_sel_i ? a_write_i : b_write_i;
   assign bus_cmd_o   = probe_sel_i ? a_cmd_i : b_cmd_i;

   // only the owner of the bus sees read data.
   assign a_result_o = probe_sel_i ? bus_result_i : '0;
   assign b_result_o = probe_sel_i ? '0 : bus_result_i;

endmodule

/* design/lsu_ctrl.sv */
`timescale 1ns/1ps

module lsu_ctrl
   import membus_pkg::*;
(
   input  mem_access_t access_i,
   input  word_t       byte_addr_i,
   input  word_t       store_data_i,
   input  bus_result_t bus_result_i,
   output bus_cmd_t    bus_cmd_o,
   output logic        write_o,
   output word_addr_t  word_addr_o,
   output word_t       load_data_o,
   output logic        misaligned_o
);

   logic [1:0] offset;
   logic       is_load;
   logic       is_store;
   logic       size_byte;
   logic       size_half;
   logic       is_unsigned;
   word_t      shifted;

   assign offset      = byte_addr_i[1:0];
   assign word_addr_o = byte_addr_i[31:2];

   always_comb begin
      is_load     = 1'b0;
      is_store    = 1'b0;
      size_byte   = 1'b0;
      size_half   = 1'b0;
      is_unsigned = 1'b0;
      case (access_i)
         access_lb:  begin is_load = 1'b1; size_byte = 1'b1; end
         access_lh:  begin is_load = 1'b1; size_half = 1'b1; end
         access_lw:  is_load = 1'b1;
         access_lbu: begin is_load = 1'b1; size_byte = 1'b1; is_unsigned = 1'b1; end
         access_lhu: begin is_load = 1'b1; size_half = 1'b1; is_unsigned = 1'b1; end
         access_sb:  begin is_store = 1'b1; size_byte = 1'b1; end
         access_sh:  begin is_store = 1'b1; size_half = 1'b1; end
         access_sw:  is_store = 1'b1;
         default:    ;
      endcase
   end

   // a byte never misaligns, a half needs an even address, a word needs offset zero.
   assign misaligned_o = (is_load | is_store) &
                         (size_half ? offset[0] : (!size_byte && offset != 2'b00));

   always_comb begin
      if (size_byte) begin
         bus_cmd_o.mask_byte  = 4'b0001 << offset;
         bus_cmd_o.write_data = {4{store_data_i[7:0]}};
      end else if (size_half) begin
         bus_cmd_o.mask_byte  = 4'b0011 << offset;
         bus_cmd_o.write_data = {2{store_data_i[15:0]}};
      end else begin
         bus_cmd_o.mask_byte  = 4'b1111;
         bus_cmd_o.write_data = store_data_i;
      end
      bus_cmd_o.mem_read = is_load & ~misaligned_o;
   end

   assign write_o = is_store & ~misaligned_o;

   assign shifted = bus_result_i >> {offset, 3'b000}; // addressed lane moves to bit 0.

   always_comb begin
      if (!is_load)
         load_data_o = '0;
      else if (size_byte)
         load_data_o = {{24{shifted[7] & ~is_unsigned}}, shifted[7:0]};
      else if (size_half)
         load_data_o = {{16{shifted[15] & ~is_unsigned}}, shifted[15:0]};
      else
         load_data_o = shifted;
   end

endmodule

/* common/membus_pkg.sv */
`include "membus_defs.svh"

package membus_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`WORD_ADDR_W-1:0] word_addr_t;
   typedef logic [3:0] byte_mask_t;
   typedef logic [`MEM_ADDR_BITS-1:0] mem_index_t;

   // typed access from the processor load/store port.
   typedef enum logic [3:0] {
      access_none,
      access_lb,
      access_lh,
      access_lw,
      access_lbu,
      access_lhu,
      access_sb,
      access_sh,
      access_sw
   } mem_access_t;

   typedef struct packed {
      logic       mem_read;
      byte_mask_t mask_byte;
      word_t      write_data;
   } bus_cmd_t;

   typedef word_t bus_result_t;

endpackage

/* common/membus_defs.svh */
`ifndef MEMBUS_DEFS_SVH
`define MEMBUS_DEFS_SVH

// Data word width in bits.
`define WORD_W 32

// Width of a word address.
`define WORD_ADDR_W 30

// Data memory holds 2**MEM_ADDR_BITS words.
`define MEM_ADDR_BITS 10

// Address map, in word addresses.
`define MEM_BASE 30'h1000
`define UART_BASE 30'h100
`define UART_WORDS 4

`endif
